// ==== Makefile ====
# Verilator build and run for the multiply unit testbench

VERILATOR  ?= verilator
TOP        := mul_unit_tb
FILELIST   := mul_unit.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Exit status of the simulation binary is the test result
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== common/mul_pkg.sv ====
// Shared definitions for the sequential multiply unit
// Opcode constants, sizes and the structs passed between the stages

package mul_pkg;

  // Data path width of the core
  localparam int XLEN = 32;

  // OP major opcode and the M-extension funct7
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  // Multiply funct3 codes, division codes are not handled here
  localparam logic [2:0] FUNCT3_MUL    = 3'b000;
  localparam logic [2:0] FUNCT3_MULH   = 3'b001;
  localparam logic [2:0] FUNCT3_MULHSU = 3'b010;
  localparam logic [2:0] FUNCT3_MULHU  = 3'b011;

  // Largest number of low multiplier bits that may be dropped
  localparam int MAX_SKIP = 31;

  // Width of the skip field, derived from MAX_SKIP
  localparam int SKIP_W = $clog2(MAX_SKIP + 1);

  // Iteration counter width, must hold XLEN
  localparam int ITER_W = 6;

  // One request as seen on the issue side
  typedef struct packed {
    logic [6:0]      opcode;
    logic [6:0]      funct7;
    logic [2:0]      funct3;
    // Requested accuracy, 0 is exact
    logic [7:0]      accuracy_level;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
  } mul_req_t;

  // Decoded operation handed to the iterative core
  typedef struct packed {
    // Encoding is not one of the four multiplies
    logic              illegal;
    // Return bits 63:32 of the product
    logic              high;
    // Product magnitude must be negated at the end
    logic              negate;
    logic [XLEN-1:0]   mag_1;
    logic [XLEN-1:0]   mag_2;
    // Low multiplier bits left out of the sum
    logic [SKIP_W-1:0] skip;
    // Number of add cycles
    logic [ITER_W-1:0] iterations;
  } mul_op_t;

  // Raw product and the flags that travel with it
  typedef struct packed {
    // Unsigned magnitude of the full product
    logic [2*XLEN-1:0] product;
    logic              negate;
    logic              high;
    logic              illegal;
  } mul_prod_t;

  // Response word returned to the core
  typedef struct packed {
    logic [XLEN-1:0] result;
    logic            illegal;
  } mul_resp_t;

endpackage

// ==== mul_unit.f ====
common/mul_pkg.sv
mul_unit/mul_decode.sv
mul_unit/mul_iterate.sv
mul_unit/mul_result.sv
mul_unit/mul_unit.sv
verif/mul_clock_gen.sv
verif/mul_unit_tb.sv

// ==== mul_unit/mul_decode.sv ====
// Multiply instruction decode
// Picks operand signedness, forms magnitudes, sign and iteration count
`timescale 1ns/100ps

module mul_decode
  import mul_pkg::*;
(
  input  mul_req_t req,
  output mul_op_t  op
);

  // Encoding matches the OP opcode with the M-extension funct7
  logic is_muldiv;
  // funct3 is one of the four multiplies
  logic is_mul_f3;
  logic legal;
  // Per-operand signedness from the instruction
  logic signed_1;
  logic signed_2;
  // Operand is read as signed and is negative
  logic neg_1;
  logic neg_2;
  // Accuracy level clamped to the skip range
  logic [SKIP_W-1:0] skip;

  always_comb begin
    is_muldiv = (req.opcode == OPCODE_OP) && (req.funct7 == FUNCT7_MULDIV);
    is_mul_f3 = (req.funct3 == FUNCT3_MUL) || (req.funct3 == FUNCT3_MULH) ||
                (req.funct3 == FUNCT3_MULHSU) || (req.funct3 == FUNCT3_MULHU);
    legal     = is_muldiv && is_mul_f3;

    // rs1 is signed for all but MULHU
    signed_1 = (req.funct3 != FUNCT3_MULHU);
    // rs2 is signed only for MUL and MULH
    signed_2 = (req.funct3 == FUNCT3_MUL) || (req.funct3 == FUNCT3_MULH);

    neg_1 = signed_1 && req.rs1[XLEN-1];
    neg_2 = signed_2 && req.rs2[XLEN-1];

    // Levels above MAX_SKIP saturate
    if (req.accuracy_level > 8'(MAX_SKIP)) begin
      skip = SKIP_W'(MAX_SKIP);
    end else begin
      skip = req.accuracy_level[SKIP_W-1:0];
    end
  end

  always_comb begin
    op.illegal = !legal;
    // Only MUL returns the low word
    op.high    = legal && (req.funct3 != FUNCT3_MUL);
    op.negate  = legal && (neg_1 ^ neg_2);

    // Two's complement magnitude
    // The most negative value maps to 2^31 unsigned
    op.mag_1 = neg_1 ? (~req.rs1 + 1'b1) : req.rs1;
    op.mag_2 = neg_2 ? (~req.rs2 + 1'b1) : req.rs2;

    op.skip = skip;

    // Each skipped bit saves one add cycle
    // Illegal ops finish at once
    if (legal) begin
      op.iterations = ITER_W'(XLEN) - ITER_W'(skip);
    end else begin
      op.iterations = '0;
    end
  end

endmodule

// ==== mul_unit/mul_iterate.sv ====
// Iterative shift-add multiplier core
// Adds one shifted multiplicand per set multiplier bit, starting at skip
// Lower accuracy levels drop low multiplier bits and save cycles
`timescale 1ns/100ps

module mul_iterate
  import mul_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      start,
  input  mul_op_t   op,
  output logic      done,
  output mul_prod_t prod
);

  // Operation in progress
  logic              active;
  // Remaining add cycles
  logic [ITER_W-1:0] cnt;
  // Current multiplier bit position
  logic [SKIP_W-1:0] pos;

  // Latched operand magnitudes
  logic [XLEN-1:0]   mcand;
  logic [XLEN-1:0]   mplier;
  // Running sum of partial products
  logic [2*XLEN-1:0] acc;
  // Flags carried to the result stage
  logic              negate_q;
  logic              high_q;
  logic              illegal_q;

  // Mask that clears the low skip bits of the multiplier
  logic [XLEN-1:0]   skip_mask;
  // Partial product for the current bit
  logic [2*XLEN-1:0] addend;

  assign skip_mask = {XLEN{1'b1}} << op.skip;

  always_comb begin
    if (mplier[pos]) begin
      addend = {{XLEN{1'b0}}, mcand} << pos;
    end else begin
      addend = '0;
    end
  end

  // Done once the counter has drained, one cycle only
  assign done = active && (cnt == '0);

  // Control state
  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
      cnt    <= '0;
    end else if (start) begin
      active <= 1'b1;
      cnt    <= op.iterations;
    end else if (done) begin
      active <= 1'b0;
    end else if (active) begin
      cnt <= cnt - 1'b1;
    end
  end

  // Operand and accumulator registers
  always_ff @(posedge clk) begin
    if (start) begin
      mcand     <= op.mag_1;
      mplier    <= op.mag_2 & skip_mask;
      pos       <= op.skip;
      acc       <= '0;
      negate_q  <= op.negate;
      high_q    <= op.high;
      illegal_q <= op.illegal;
    end else if (active && (cnt != '0)) begin
      // One multiplier bit per cycle, walking upward
      acc <= acc + addend;
      pos <= pos + 1'b1;
    end
  end

  always_comb begin
    prod.product = acc;
    prod.negate  = negate_q;
    prod.high    = high_q;
    prod.illegal = illegal_q;
  end

  // The issue side must hold off while an operation is running
  start_while_active: assert property (
    @(posedge clk) disable iff (rst) start |-> !active
  ) else $error("mul_iterate: start while an operation is running");

  // done is a single-cycle pulse
  done_one_cycle: assert property (
    @(posedge clk) disable iff (rst) done |=> !done
  ) else $error("mul_iterate: done held for more than one cycle");

endmodule

// ==== mul_unit/mul_result.sv ====
// Multiply result stage
// Applies the product sign, selects the word and registers the response
`timescale 1ns/100ps

module mul_result
  import mul_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      done,
  input  mul_prod_t prod,
  output logic      resp_valid,
  output mul_resp_t resp
);

  // Product with the sign applied
  logic [2*XLEN-1:0] signed_prod;
  // Selected word before registering
  logic [XLEN-1:0]   word;

  always_comb begin
    // Two's complement negation of the magnitude
    if (prod.negate) begin
      signed_prod = ~prod.product + 1'b1;
    end else begin
      signed_prod = prod.product;
    end

    // Illegal encodings return zero
    if (prod.illegal) begin
      word = '0;
    end else if (prod.high) begin
      word = signed_prod[2*XLEN-1:XLEN];
    end else begin
      word = signed_prod[XLEN-1:0];
    end
  end

  // Valid strobe follows done by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= done;
    end
  end

  // Response payload, only updated on done
  always_ff @(posedge clk) begin
    if (done) begin
      resp.result  <= word;
      resp.illegal <= prod.illegal;
    end
  end

  // No back-pressure, so the response lasts exactly one cycle
  resp_valid_pulse: assert property (
    @(posedge clk) disable iff (rst) resp_valid |=> !resp_valid
  ) else $error("mul_result: resp_valid high for two cycles in a row");

endmodule

// ==== mul_unit/mul_unit.sv ====
// Sequential multiply unit for the RISC-V M extension
// Decode, shift-add iteration and result stages with a busy handshake
`timescale 1ns/100ps

module mul_unit
  import mul_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      req_valid,
  input  mul_req_t  req,
  output logic      busy,
  output logic      resp_valid,
  output mul_resp_t resp
);

  // Accept strobe into the core
  logic      start;
  // One-cycle end of iteration
  logic      done;
  // Decoded request
  mul_op_t   op;
  // Unsigned product and flags
  mul_prod_t prod;

  // Requests are only taken while idle
  assign start = req_valid && !busy;

  // Busy from the cycle after accept until done
  // Cleared in time for a new accept in the response cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
    end else if (start) begin
      busy <= 1'b1;
    end else if (done) begin
      busy <= 1'b0;
    end
  end

  // Combinational decode of the incoming request
  mul_decode u_decode (
    .req (req),
    .op  (op)
  );

  // Multi-cycle shift-add core
  mul_iterate u_iterate (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .op    (op),
    .done  (done),
    .prod  (prod)
  );

  // Sign fix-up and word select
  mul_result u_result (
    .clk        (clk),
    .rst        (rst),
    .done       (done),
    .prod       (prod),
    .resp_valid (resp_valid),
    .resp       (resp)
  );

endmodule

// ==== verif/mul_clock_gen.sv ====
// Testbench clock source for the multiply unit
// Free-running clock with a 4 ns period
`timescale 1ns/100ps

module mul_clock_gen (
  output logic clk
);

  // Half period of 2 ns gives the 4 ns cycle
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

endmodule

// ==== verif/mul_unit_tb.sv ====
// Testbench for the sequential multiply unit
// Random requests from an xorshift source, checked against a reference model
`timescale 1ns/100ps

module mul_unit_tb
  import mul_pkg::*;
();

  logic      clk;
  logic      rst;
  logic      req_valid;
  mul_req_t  req;
  logic      busy;
  logic      resp_valid;
  mul_resp_t resp;

  // Random source state
  logic [31:0] rng_state;
  // Next request already on the bus from the previous response cycle
  logic        preloaded;

  mul_clock_gen u_clk (
    .clk (clk)
  );

  mul_unit UUT (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req        (req),
    .busy       (busy),
    .resp_valid (resp_valid),
    .resp       (resp)
  );

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Operands lean toward the usual corner values
  function automatic logic [XLEN-1:0] pick_operand();
    logic [31:0] sel;
    sel = next_rand();
    case (sel[2:0])
      3'd0: return '0;
      3'd1: return 32'd1;
      3'd2: return '1;
      3'd3: return 32'h8000_0000;
      default: return next_rand();
    endcase
  endfunction

  function automatic mul_req_t make_legal(input logic [2:0] f3, input logic [7:0] level);
    mul_req_t r;
    r.opcode         = OPCODE_OP;
    r.funct7         = FUNCT7_MULDIV;
    r.funct3         = f3;
    r.accuracy_level = level;
    r.rs1            = pick_operand();
    r.rs2            = pick_operand();
    return r;
  endfunction

  // Breaks exactly one field of an otherwise legal multiply
  function automatic mul_req_t make_illegal();
    mul_req_t    r;
    logic [31:0] sel;
    sel = next_rand();
    r = make_legal(sel[4:2], sel[23:16]);
    case (sel[1:0])
      2'd0: begin
        r.opcode = sel[14:8];
        if (r.opcode == OPCODE_OP) begin
          r.opcode = r.opcode ^ 7'h04;
        end
      end
      2'd1: begin
        r.funct7 = sel[14:8];
        if (r.funct7 == FUNCT7_MULDIV) begin
          r.funct7 = r.funct7 ^ 7'h20;
        end
      end
      // Division codes are outside the unit
      default: r.funct3 = {1'b1, sel[6:5]};
    endcase
    return r;
  endfunction

  // Reference model
  function automatic logic is_mul_encoding(input mul_req_t r);
    if (r.opcode != OPCODE_OP || r.funct7 != FUNCT7_MULDIV) begin
      return 1'b0;
    end
    case (r.funct3)
      FUNCT3_MUL, FUNCT3_MULH, FUNCT3_MULHSU, FUNCT3_MULHU: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic int model_skip(input mul_req_t r);
    if (int'(r.accuracy_level) > MAX_SKIP) begin
      return MAX_SKIP;
    end
    return int'(r.accuracy_level);
  endfunction

  function automatic int model_iterations(input mul_req_t r);
    if (!is_mul_encoding(r)) begin
      return 0;
    end
    return XLEN - model_skip(r);
  endfunction

  function automatic mul_resp_t model_resp(input mul_req_t r);
    mul_resp_t          res;
    logic signed [63:0] a;
    logic signed [63:0] b;
    logic [63:0]        mag_a;
    logic [63:0]        mag_b;
    logic [63:0]        p;
    res = '0;
    if (!is_mul_encoding(r)) begin
      res.illegal = 1'b1;
      return res;
    end
    // rs1 signed except for MULHU
    if (r.funct3 == FUNCT3_MULHU) begin
      a = {{XLEN{1'b0}}, r.rs1};
    end else begin
      a = {{XLEN{r.rs1[XLEN-1]}}, r.rs1};
    end
    // rs2 signed only for MUL and MULH
    if (r.funct3 == FUNCT3_MUL || r.funct3 == FUNCT3_MULH) begin
      b = {{XLEN{r.rs2[XLEN-1]}}, r.rs2};
    end else begin
      b = {{XLEN{1'b0}}, r.rs2};
    end
    mag_a = a[63] ? -a : a;
    mag_b = b[63] ? -b : b;
    // Approximation drops the low multiplier bits
    mag_b = mag_b & ({2*XLEN{1'b1}} << model_skip(r));
    p = mag_a * mag_b;
    if (a[63] ^ b[63]) begin
      p = -p;
    end
    res.result = (r.funct3 == FUNCT3_MUL) ? p[31:0] : p[63:32];
    return res;
  endfunction

  // Compare tasks
  task automatic check_resp(input mul_resp_t got, input mul_resp_t exp);
    if (got.result !== exp.result) begin
      $display("error resp.result: got 0x%h expected 0x%h", got.result, exp.result);
      abort_run();
    end
  endtask

  task automatic check_illegal(input mul_resp_t got, input mul_resp_t exp);
    if (got.illegal !== exp.illegal) begin
      $display("error resp.illegal: got 0x%h expected 0x%h", got.illegal, exp.illegal);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %s: got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp) begin
      $display("error latency: got 0x%h expected 0x%h", got, exp);
      abort_run();
    end
  endtask

  task automatic wait_idle();
    int k;
    k = 0;
    @(negedge clk);
    while (busy && k < 2 * XLEN) begin
      @(negedge clk);
      k++;
    end
    if (busy) begin
      $display("busy did not go low within %0d cycles", 2 * XLEN);
      abort_run();
    end
  endtask

  // One request from accept to response
  // With chain set the next request goes out in the response cycle
  task automatic run_request(input mul_req_t r, input logic chain, input mul_req_t next_r);
    mul_resp_t exp;
    int        n;
    int        k;
    logic      seen;
    exp = model_resp(r);
    n = model_iterations(r);
    if (!preloaded) begin
      wait_idle();
      @(posedge clk);
      req_valid <= 1'b1;
      req       <= r;
    end
    // Accept edge
    @(posedge clk);
    req_valid <= 1'b0;
    k = 0;
    seen = 1'b0;
    while (!seen && k < 2 * XLEN) begin
      @(negedge clk);
      k++;
      if (resp_valid) begin
        seen = 1'b1;
      end else begin
        check_flag("busy", busy, 1'b1);
        // Next edge raises resp_valid, so the request is seen in that cycle
        if (chain && k == n + 1) begin
          @(posedge clk);
          req_valid <= 1'b1;
          req       <= next_r;
        end
      end
    end
    if (!seen) begin
      $display("response did not arrive within %0d cycles of the accept", 2 * XLEN);
      abort_run();
    end else begin
      check_latency(k, n + 2);
      check_flag("busy", busy, 1'b0);
      check_resp(resp, exp);
      check_illegal(resp, exp);
      preloaded = chain;
    end
  endtask

  task automatic run_batch(input mul_req_t reqs[$]);
    int          idx;
    logic [31:0] s;
    for (idx = 0; idx < reqs.size(); idx++) begin
      s = next_rand();
      if (idx + 1 < reqs.size() && s[0]) begin
        run_request(reqs[idx], 1'b1, reqs[idx + 1]);
      end else begin
        run_request(reqs[idx], 1'b0, '0);
      end
    end
  endtask

  // Power-on reset with outputs low throughout and just after
  task automatic reset_checks();
    int i;
    for (i = 1; i <= 8; i++) begin
      @(posedge clk);
      if (i == 8) begin
        rst <= 1'b0;
      end
      @(negedge clk);
      check_flag("busy", busy, 1'b0);
      check_flag("resp_valid", resp_valid, 1'b0);
    end
    @(negedge clk);
    check_flag("busy", busy, 1'b0);
    check_flag("resp_valid", resp_valid, 1'b0);
  endtask

  // Full-length MUL cut short by reset
  // No response may follow
  task automatic reset_during_op();
    int k;
    wait_idle();
    @(posedge clk);
    req_valid <= 1'b1;
    req       <= make_legal(FUNCT3_MUL, 8'd0);
    @(posedge clk);
    req_valid <= 1'b0;
    // The operation must have started before reset cuts it
    @(negedge clk);
    check_flag("busy", busy, 1'b1);
    repeat (5) @(posedge clk);
    rst <= 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (k = 0; k < 40; k++) begin
      @(negedge clk);
      check_flag("resp_valid", resp_valid, 1'b0);
      check_flag("busy", busy, 1'b0);
    end
  endtask

  initial begin
    int          i;
    logic [31:0] s;
    logic [2:0]  f3;
    mul_req_t    batch[$];
    rng_state = 32'd85;
    preloaded = 1'b0;
    rst       = 1'b1;
    req_valid = 1'b0;
    req       = '0;

    reset_checks();

    // Exact MUL, low word
    for (i = 0; i < 300; i++) begin
      batch.push_back(make_legal(FUNCT3_MUL, 8'd0));
    end
    run_batch(batch);
    batch.delete();

    // High word variants at full accuracy
    for (i = 0; i < 300; i++) begin
      s = next_rand();
      case (s % 3)
        0: f3 = FUNCT3_MULH;
        1: f3 = FUNCT3_MULHSU;
        default: f3 = FUNCT3_MULHU;
      endcase
      batch.push_back(make_legal(f3, 8'd0));
    end
    run_batch(batch);
    batch.delete();

    // Approximate products with half of the levels within the skip range
    for (i = 0; i < 300; i++) begin
      s = next_rand();
      batch.push_back(make_legal({1'b0, s[1:0]}, s[8] ? s[7:0] : {3'b000, s[4:0]}));
    end
    run_batch(batch);
    batch.delete();

    // Illegal encodings
    for (i = 0; i < 60; i++) begin
      batch.push_back(make_illegal());
    end
    run_batch(batch);
    batch.delete();

    // Mixed traffic with illegal ops between legal ones
    for (i = 0; i < 200; i++) begin
      s = next_rand();
      if (s[3:0] == 4'd0) begin
        batch.push_back(make_illegal());
      end else begin
        batch.push_back(make_legal({1'b0, s[5:4]}, s[23:16]));
      end
    end
    run_batch(batch);
    batch.delete();

    reset_during_op();

    // Unit recovers after the interrupted operation
    for (i = 0; i < 20; i++) begin
      s = next_rand();
      batch.push_back(make_legal({1'b0, s[1:0]}, {3'b000, s[12:8]}));
    end
    run_batch(batch);
    batch.delete();

    $display("TEST OK");
    $finish;
  end

endmodule
